//--- sim/vector_golden.txt
# I reconfig op dst src1 src2 scalar
# E ticket reg mask data(lane3..lane0) scalar_flag sum, all fields hex
# broadcast four registers
I 0 06 01 00 00 000000f0
E 1 01 f 000000f0000000f0000000f0000000f0 0 000003c0
I 0 06 02 00 00 0000003c
E 2 02 f 0000003c0000003c0000003c0000003c 0 000000f0
I 0 06 03 00 00 ffffff00
E 3 03 f ffffff00ffffff00ffffff00ffffff00 0 fffffc00
I 0 06 04 00 00 00000001
E 4 04 f 00000001000000010000000100000001 0 00000004
# element-wise ops
I 0 00 05 01 02 00000000
E 5 05 f 0000012c0000012c0000012c0000012c 0 000004b0
I 0 01 06 02 01 00000000
E 6 06 f ffffff4cffffff4cffffff4cffffff4c 0 fffffd30
I 0 02 07 01 02 00000000
E 7 07 f 00000030000000300000003000000030 0 000000c0
I 0 03 08 01 02 00000000
E 8 08 f 000000fc000000fc000000fc000000fc 0 000003f0
I 0 04 09 01 02 00000000
E 9 09 f 000000cc000000cc000000cc000000cc 0 00000330
I 0 05 0a 03 00 00000200
E a 0a f 00000100000001000000010000000100 0 00000400
# dependent chain right behind its producer
I 0 00 0b 0a 04 00000000
E b 0b f 00000101000001010000010100000101 0 00000404
I 0 00 0c 0b 0b 00000000
E c 0c f 00000202000002020000020200000202 0 00000808
I 0 04 0d 0c 09 00000000
E d 0d f 000002ce000002ce000002ce000002ce 0 00000b38
I 0 01 0e 04 0d 00000000
E e 0e f fffffd33fffffd33fffffd33fffffd33 0 fffff4cc
I 0 03 0f 03 04 00000000
E f 0f f ffffff01ffffff01ffffff01ffffff01 0 fffffc04
# ticket wraps to 1
I 0 02 10 03 0e 00000000
E 1 10 f fffffd00fffffd00fffffd00fffffd00 0 fffff400
I 0 07 1f 05 00 00000000
E 2 1f f 0000012c0000012c0000012c0000012c 1 000004b0
# vl 2 masks lanes 2 and 3
I 1 00 00 00 00 00000002
I 0 06 03 00 00 00000055
E 1 03 3 00000000000000000000005500000055 0 000000aa
I 0 00 11 03 04 00000000
E 2 11 3 00000000000000000000005600000056 0 000000ac
I 0 07 02 03 00 00000000
E 3 02 3 00000000000000000000005500000055 1 000000aa
# vl 7 clamps to 4, old lane values return
I 1 00 00 00 00 00000007
I 0 05 12 03 00 00000000
E 1 12 f ffffff00ffffff000000005500000055 0 fffffeaa
I 0 07 04 03 00 00000000
E 2 04 f ffffff00ffffff000000005500000055 1 fffffeaa
I 0 01 13 12 03 00000000
E 3 13 f 00000000000000000000000000000000 0 00000000
I 0 04 14 12 0f 00000000
E 4 14 f 0000000100000001ffffff54ffffff54 0 fffffeaa
# vl 1, then an unknown op code
I 1 00 00 00 00 00000001
I 0 02 15 14 14 00000000
E 1 15 1 000000000000000000000000ffffff54 0 ffffff54
I 0 1f 16 14 14 00000000
E 2 16 1 00000000000000000000000000000000 0 00000000
I 1 00 00 00 00 00000004
I 0 00 18 11 01 00000000
E 1 18 f 000000f0000000f00000014600000146 0 0000046c

//--- files.f
hw/vec_pkg.sv
hw/vector_issue_queue.sv
hw/vector_dispatch.sv
hw/vector_lane.sv
hw/vector_writeback.sv
hw/vector_top.sv
sim/vector_props.sv
sim/vector_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vector_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/vector_tb.sv
module vector_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vec_pkg::*;

    localparam int          LANES      = 4;
    localparam int          DEPTH      = 4;
    localparam int          DATA_W     = LANES * ELEM_W;
    localparam int          WAIT_LIMIT = 500;
    localparam logic [31:0] LFSR_SEED  = 32'h96aaee4d;
    localparam logic [31:0] LFSR_POLY  = 32'h80200003;

    typedef struct packed {
        logic     reconfig;
        microop_t op;
        reg_idx_t dst;
        reg_idx_t src1;
        reg_idx_t src2;
        elem_t    scalar;
    } instr_t;

    typedef struct packed {
        ticket_t           ticket;
        reg_idx_t          dst;
        logic [LANES-1:0]  mask;
        logic [DATA_W-1:0] data;
        logic              scalar;
        elem_t             sum;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              vector_valid_i;
    logic              vector_ready_o;
    logic              reconfig_i;
    microop_t          microop_i;
    reg_idx_t          dst_i;
    reg_idx_t          src1_i;
    reg_idx_t          src2_i;
    elem_t             scalar_i;
    logic              result_valid_o;
    logic              result_ready_i;
    ticket_t           result_ticket_o;
    reg_idx_t          result_reg_o;
    logic [LANES-1:0]  result_mask_o;
    logic [DATA_W-1:0] result_data_o;
    logic              result_scalar_o;
    elem_t             result_sum_o;

    instr_t      instr_q [$];
    expect_t     expect_q [$];
    logic [31:0] lfsr;

    vector_top #(
        .VECTOR_LANES (LANES),
        .VIQ_DEPTH    (DEPTH)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .vector_valid_i  (vector_valid_i),
        .vector_ready_o  (vector_ready_o),
        .reconfig_i      (reconfig_i),
        .microop_i       (microop_i),
        .dst_i           (dst_i),
        .src1_i          (src1_i),
        .src2_i          (src2_i),
        .scalar_i        (scalar_i),
        .result_valid_o  (result_valid_o),
        .result_ready_i  (result_ready_i),
        .result_ticket_o (result_ticket_o),
        .result_reg_o    (result_reg_o),
        .result_mask_o   (result_mask_o),
        .result_data_o   (result_data_o),
        .result_scalar_o (result_scalar_o),
        .result_sum_o    (result_sum_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ LFSR_POLY;
        end
        return shifted;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at %0d ns: %s is %0h, expected %0h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic load_golden();
        int                fd;
        int                n;
        string             line;
        logic [31:0]       a0, a1, a2, a3, a4, a5;
        logic [DATA_W-1:0] d;
        fd = $fopen("sim/vector_golden.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the golden file sim/vector_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            if (line[0] == "I") begin
                n = $sscanf(line, "I %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5);
                if (n != 6) begin
                    abort_run($sformatf("malformed instruction line: %s", line));
                end
                instr_q.push_back({a0[0], a1[4:0], a2[4:0], a3[4:0], a4[4:0], a5});
            end else if (line[0] == "E") begin
                n = $sscanf(line, "E %h %h %h %h %h %h", a0, a1, a2, d, a4, a5);
                if (n != 6) begin
                    abort_run($sformatf("malformed expected line: %s", line));
                end
                expect_q.push_back({a0[3:0], a1[4:0], a2[LANES-1:0], d, a4[0], a5});
            end else begin
                abort_run($sformatf("unknown line in golden file: %s", line));
            end
        end
        $fclose(fd);
    endtask

    // one instruction per call, held until vector_ready_o
    task automatic send_instr(input instr_t ins);
        int waited;
        @(negedge clk);
        vector_valid_i = 1'b1;
        reconfig_i     = ins.reconfig;
        microop_i      = ins.op;
        dst_i          = ins.dst;
        src1_i         = ins.src1;
        src2_i         = ins.src2;
        scalar_i       = ins.scalar;
        waited         = 0;
        while (!vector_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout: vector_ready_o stayed low, instruction never accepted");
            end
            @(negedge clk);
        end
    endtask

    task automatic drive_all();
        while (instr_q.size() > 0) begin
            send_instr(instr_q.pop_front());
        end
        @(negedge clk);
        vector_valid_i = 1'b0;
    endtask

    // random back-pressure, one lfsr step per cycle
    task automatic step_ready();
        @(negedge clk);
        lfsr           = lfsr_step(lfsr);
        result_ready_i = lfsr[0];
    endtask

    task automatic collect_results();
        expect_t exp_r;
        int      waited;
        int      num;
        num = 0;
        while (expect_q.size() > 0) begin
            exp_r  = expect_q.pop_front();
            waited = 0;
            step_ready();
            while (!(result_valid_o && result_ready_i)) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run($sformatf("timeout: result %0d never appeared on result_valid_o",
                                        num));
                end
                step_ready();
            end
            check_value("result_ticket_o", DATA_W'(result_ticket_o), DATA_W'(exp_r.ticket));
            check_value("result_reg_o", DATA_W'(result_reg_o), DATA_W'(exp_r.dst));
            check_value("result_mask_o", DATA_W'(result_mask_o), DATA_W'(exp_r.mask));
            check_value("result_data_o", result_data_o, exp_r.data);
            check_value("result_scalar_o", DATA_W'(result_scalar_o), DATA_W'(exp_r.scalar));
            check_value("result_sum_o", DATA_W'(result_sum_o), DATA_W'(exp_r.sum));
            num++;
        end
    endtask

    // nothing may follow the last expected result
    task automatic drain_check();
        repeat (20) begin
            @(negedge clk);
            result_ready_i = 1'b1;
            if (result_valid_o) begin
                abort_run("an extra result appeared after the last expected one");
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        vector_valid_i = 1'b0;
        reconfig_i     = 1'b0;
        microop_i      = '0;
        dst_i          = '0;
        src1_i         = '0;
        src2_i         = '0;
        scalar_i       = '0;
        result_ready_i = 1'b0;
        lfsr           = LFSR_SEED;
        load_golden();
        if (expect_q.size() == 0) begin
            abort_run("the golden file holds no expected results");
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        fork
            drive_all();
            collect_results();
        join
        drain_check();
        $display("Test OK");
        $finish;
    end

endmodule

//--- sim/vector_props.sv
module vector_props #(
    parameter int VECTOR_LANES = 4
) (
    input logic                                    clk,
    input logic                                    rst_n,
    input logic                                    vector_ready_o,
    input logic                                    result_valid_o,
    input logic                                    result_ready_i,
    input vec_pkg::ticket_t                        result_ticket_o,
    input vec_pkg::reg_idx_t                       result_reg_o,
    input logic [VECTOR_LANES-1:0]                 result_mask_o,
    input logic [VECTOR_LANES*vec_pkg::ELEM_W-1:0] result_data_o,
    input logic                                    result_scalar_o,
    input vec_pkg::elem_t                          result_sum_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled result keeps every field
    output_held: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid_o && !result_ready_i |=> result_valid_o
            && $stable(result_ticket_o) && $stable(result_reg_o)
            && $stable(result_mask_o) && $stable(result_data_o)
            && $stable(result_scalar_o) && $stable(result_sum_o))
        else $error("result output changed or dropped while stalled");

    ticket_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid_o |-> result_ticket_o != '0)
        else $error("result carries ticket 0");

    ready_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> vector_ready_o)
        else $error("vector_ready_o low in the first cycle after reset");

endmodule

bind vector_top vector_props #(
    .VECTOR_LANES (VECTOR_LANES)
) u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .vector_ready_o  (vector_ready_o),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .result_ticket_o (result_ticket_o),
    .result_reg_o    (result_reg_o),
    .result_mask_o   (result_mask_o),
    .result_data_o   (result_data_o),
    .result_scalar_o (result_scalar_o),
    .result_sum_o    (result_sum_o)
);

//--- hw/vector_top.sv
module vector_top #(
    parameter int VECTOR_LANES = 4,
    parameter int VIQ_DEPTH    = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    vector_valid_i,
    output logic                                    vector_ready_o,
    input  logic                                    reconfig_i,
    input  vec_pkg::microop_t                       microop_i,
    input  vec_pkg::reg_idx_t                       dst_i,
    input  vec_pkg::reg_idx_t                       src1_i,
    input  vec_pkg::reg_idx_t                       src2_i,
    input  vec_pkg::elem_t                          scalar_i,
    output logic                                    result_valid_o,
    input  logic                                    result_ready_i,
    output vec_pkg::ticket_t                        result_ticket_o,
    output vec_pkg::reg_idx_t                       result_reg_o,
    output logic [VECTOR_LANES-1:0]                 result_mask_o,
    output logic [VECTOR_LANES*vec_pkg::ELEM_W-1:0] result_data_o,
    output logic                                    result_scalar_o,
    output vec_pkg::elem_t                          result_sum_o
);
    import vec_pkg::*;

    localparam int VL_W = $clog2(VECTOR_LANES + 1);

    // broadcast bundle
    logic            lane_valid;
    logic            lane_ready;
    microop_t        bc_op;
    reg_idx_t        bc_dst;
    reg_idx_t        bc_src1;
    reg_idx_t        bc_src2;
    elem_t           bc_scalar;
    ticket_t         bc_ticket;
    logic [VL_W-1:0] bc_vl;

    // per-lane outputs
    logic [VECTOR_LANES-1:0]        lane_ready_vec;
    logic [VECTOR_LANES-1:0]        lane_out_valid;
    logic [VECTOR_LANES*ELEM_W-1:0] lane_elem;
    logic [VECTOR_LANES-1:0]        lane_active;
    ticket_t                        lane_ticket [VECTOR_LANES];
    reg_idx_t                       lane_dst [VECTOR_LANES];
    microop_t                       lane_op [VECTOR_LANES];
    logic                           wb_ready;

    vector_dispatch #(
        .VECTOR_LANES (VECTOR_LANES),
        .VIQ_DEPTH    (VIQ_DEPTH)
    ) u_dispatch (
        .clk            (clk),
        .rst_n          (rst_n),
        .vector_valid_i (vector_valid_i),
        .vector_ready_o (vector_ready_o),
        .reconfig_i     (reconfig_i),
        .microop_i      (microop_i),
        .dst_i          (dst_i),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .scalar_i       (scalar_i),
        .lane_valid_o   (lane_valid),
        .lane_ready_i   (lane_ready),
        .op_o           (bc_op),
        .dst_o          (bc_dst),
        .src1_o         (bc_src1),
        .src2_o         (bc_src2),
        .scalar_o       (bc_scalar),
        .ticket_o       (bc_ticket),
        .vl_o           (bc_vl)
    );

    // lanes accept in lockstep, lane 0 speaks for all
    assign lane_ready = lane_ready_vec[0];

    for (genvar g = 0; g < VECTOR_LANES; g++) begin : g_lane
        vector_lane #(
            .LANE_INDEX   (g),
            .VECTOR_LANES (VECTOR_LANES)
        ) u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .valid_i      (lane_valid),
            .ready_o      (lane_ready_vec[g]),
            .op_i         (bc_op),
            .dst_i        (bc_dst),
            .src1_i       (bc_src1),
            .src2_i       (bc_src2),
            .scalar_i     (bc_scalar),
            .ticket_i     (bc_ticket),
            .vl_i         (bc_vl),
            .out_valid_o  (lane_out_valid[g]),
            .out_ready_i  (wb_ready),
            .out_elem_o   (lane_elem[g*ELEM_W +: ELEM_W]),
            .out_active_o (lane_active[g]),
            .out_ticket_o (lane_ticket[g]),
            .out_dst_o    (lane_dst[g]),
            .out_op_o     (lane_op[g])
        );
    end

    vector_writeback #(
        .VECTOR_LANES (VECTOR_LANES)
    ) u_writeback (
        .clk             (clk),
        .rst_n           (rst_n),
        .lane_valid_i    (lane_out_valid[0]),
        .lane_ready_o    (wb_ready),
        .lane_elem_i     (lane_elem),
        .lane_active_i   (lane_active),
        .ticket_i        (lane_ticket[0]),
        .dst_i           (lane_dst[0]),
        .op_i            (lane_op[0]),
        .result_valid_o  (result_valid_o),
        .result_ready_i  (result_ready_i),
        .result_ticket_o (result_ticket_o),
        .result_reg_o    (result_reg_o),
        .result_mask_o   (result_mask_o),
        .result_data_o   (result_data_o),
        .result_scalar_o (result_scalar_o),
        .result_sum_o    (result_sum_o)
    );

endmodule

//--- hw/vector_writeback.sv
module vector_writeback #(
    parameter int VECTOR_LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     lane_valid_i,
    output logic                                     lane_ready_o,
    input  logic [VECTOR_LANES*vec_pkg::ELEM_W-1:0]  lane_elem_i,
    input  logic [VECTOR_LANES-1:0]                  lane_active_i,
    input  vec_pkg::ticket_t                         ticket_i,
    input  vec_pkg::reg_idx_t                        dst_i,
    input  vec_pkg::microop_t                        op_i,
    output logic                                     result_valid_o,
    input  logic                                     result_ready_i,
    output vec_pkg::ticket_t                         result_ticket_o,
    output vec_pkg::reg_idx_t                        result_reg_o,
    output logic [VECTOR_LANES-1:0]                  result_mask_o,
    output logic [VECTOR_LANES*vec_pkg::ELEM_W-1:0]  result_data_o,
    output logic                                     result_scalar_o,
    output vec_pkg::elem_t                           result_sum_o
);
    import vec_pkg::*;

    elem_t lane_sum;
    logic  take;

    // wraps at 32 bits
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < VECTOR_LANES; i++) begin
            if (lane_active_i[i]) begin
                lane_sum = lane_sum + lane_elem_i[i*ELEM_W +: ELEM_W];
            end
        end
    end

    assign lane_ready_o = ~result_valid_o | result_ready_i;
    assign take         = lane_valid_i & lane_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
        end else if (lane_ready_o) begin
            result_valid_o <= lane_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result_ticket_o <= ticket_i;
            result_reg_o    <= dst_i;
            result_mask_o   <= lane_active_i;
            result_data_o   <= lane_elem_i;
            result_scalar_o <= (op_i == OP_VREDSUM_VS);
            result_sum_o    <= lane_sum;
        end
    end

endmodule

//--- hw/vector_lane.sv
module vector_lane #(
    parameter int LANE_INDEX   = 0,
    parameter int VECTOR_LANES = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid_i,
    output logic                              ready_o,
    input  vec_pkg::microop_t                 op_i,
    input  vec_pkg::reg_idx_t                 dst_i,
    input  vec_pkg::reg_idx_t                 src1_i,
    input  vec_pkg::reg_idx_t                 src2_i,
    input  vec_pkg::elem_t                    scalar_i,
    input  vec_pkg::ticket_t                  ticket_i,
    input  logic [$clog2(VECTOR_LANES+1)-1:0] vl_i,
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output vec_pkg::elem_t                    out_elem_o,
    output logic                              out_active_o,
    output vec_pkg::ticket_t                  out_ticket_o,
    output vec_pkg::reg_idx_t                 out_dst_o,
    output vec_pkg::microop_t                 out_op_o
);
    import vec_pkg::*;

    localparam int              VL_W    = $clog2(VECTOR_LANES + 1);
    localparam logic [VL_W-1:0] LANE_ID = VL_W'(LANE_INDEX);

    elem_t vregs [NUM_VREGS];
    elem_t elem_a;
    elem_t elem_b;
    elem_t alu_res;
    elem_t lane_elem;
    logic  lane_active;
    logic  take;
    logic  wr_en;

    assign lane_active = (LANE_ID < vl_i);
    assign elem_a      = vregs[src1_i];
    assign elem_b      = vregs[src2_i];

    always_comb begin
        case (op_i)
            OP_VADD_VV: alu_res = elem_a + elem_b;
            OP_VSUB_VV: alu_res = elem_a - elem_b;
            OP_VAND_VV: alu_res = elem_a & elem_b;
            OP_VOR_VV:  alu_res = elem_a | elem_b;
            OP_VXOR_VV: alu_res = elem_a ^ elem_b;
            OP_VADD_VX: alu_res = elem_a + scalar_i;
            OP_VMV_VX:  alu_res = scalar_i;
            default:    alu_res = '0;
        endcase
    end

    // reduction passes src1 on to the writeback adder
    assign lane_elem = !lane_active ? '0
                     : (op_i == OP_VREDSUM_VS) ? elem_a : alu_res;

    assign ready_o = ~out_valid_o | out_ready_i;
    assign take    = valid_i & ready_o;
    assign wr_en   = take & lane_active & (op_i != OP_VREDSUM_VS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREGS; i++) begin
                vregs[i] <= '0;
            end
        end else if (wr_en) begin
            vregs[dst_i] <= alu_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else if (ready_o) begin
            out_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_elem_o   <= lane_elem;
            out_active_o <= lane_active;
            out_ticket_o <= ticket_i;
            out_dst_o    <= dst_i;
            out_op_o     <= op_i;
        end
    end

endmodule

//--- hw/vector_dispatch.sv
module vector_dispatch #(
    parameter int VECTOR_LANES = 4,
    parameter int VIQ_DEPTH    = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              vector_valid_i,
    output logic                              vector_ready_o,
    input  logic                              reconfig_i,
    input  vec_pkg::microop_t                 microop_i,
    input  vec_pkg::reg_idx_t                 dst_i,
    input  vec_pkg::reg_idx_t                 src1_i,
    input  vec_pkg::reg_idx_t                 src2_i,
    input  vec_pkg::elem_t                    scalar_i,
    output logic                              lane_valid_o,
    input  logic                              lane_ready_i,
    output vec_pkg::microop_t                 op_o,
    output vec_pkg::reg_idx_t                 dst_o,
    output vec_pkg::reg_idx_t                 src1_o,
    output vec_pkg::reg_idx_t                 src2_o,
    output vec_pkg::elem_t                    scalar_o,
    output vec_pkg::ticket_t                  ticket_o,
    output logic [$clog2(VECTOR_LANES+1)-1:0] vl_o
);
    import vec_pkg::*;

    localparam int VL_W    = $clog2(VECTOR_LANES + 1);
    localparam int ENTRY_W = MICROOP_W + 3 * REG_IDX_W + ELEM_W + TICKET_W + VL_W;

    logic               accept;
    logic               do_reconfig;
    ticket_t            ticket_q;
    logic [VL_W-1:0]    vl_q;
    logic [VL_W-1:0]    vl_clamped;
    logic               enq_valid;
    logic               enq_ready;
    logic [ENTRY_W-1:0] enq_data;
    logic [ENTRY_W-1:0] deq_data;

    // a reconfigure also needs a free slot, so ready is the queue's
    assign vector_ready_o = enq_ready;
    assign accept         = vector_valid_i & vector_ready_o;
    assign do_reconfig    = accept & reconfig_i;

    // requested length saturates at the lane count
    assign vl_clamped = (scalar_i > elem_t'(VECTOR_LANES)) ? VL_W'(VECTOR_LANES)
                                                           : scalar_i[VL_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ticket_q <= FIRST_TICKET;
            vl_q     <= VL_W'(VECTOR_LANES);
        end else if (do_reconfig) begin
            ticket_q <= FIRST_TICKET;
            vl_q     <= vl_clamped;
        end else if (accept) begin
            // 15 wraps to 1, never 0
            ticket_q <= (&ticket_q) ? FIRST_TICKET : ticket_q + 1'b1;
        end
    end

    // reconfigures stop here
    assign enq_valid = vector_valid_i & ~reconfig_i;
    assign enq_data  = {microop_i, dst_i, src1_i, src2_i, scalar_i, ticket_q, vl_q};

    vector_issue_queue #(
        .DATA_W (ENTRY_W),
        .DEPTH  (VIQ_DEPTH)
    ) u_viq (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_valid_i (enq_valid),
        .enq_ready_o (enq_ready),
        .enq_data_i  (enq_data),
        .deq_valid_o (lane_valid_o),
        .deq_ready_i (lane_ready_i),
        .deq_data_o  (deq_data)
    );

    assign {op_o, dst_o, src1_o, src2_o, scalar_o, ticket_o, vl_o} = deq_data;

endmodule

//--- hw/vector_issue_queue.sv
module vector_issue_queue #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enq_valid_i,
    output logic              enq_ready_o,
    input  logic [DATA_W-1:0] enq_data_i,
    output logic              deq_valid_o,
    input  logic              deq_ready_i,
    output logic [DATA_W-1:0] deq_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_enq;
    logic              do_deq;

    assign enq_ready_o = (count != CNT_W'(DEPTH));
    assign deq_valid_o = (count != '0);
    assign deq_data_o  = mem[rd_ptr];
    assign do_enq      = enq_valid_i & enq_ready_o;
    assign do_deq      = deq_valid_o & deq_ready_i;

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/vec_pkg.sv
package vec_pkg;

    localparam int ELEM_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int TICKET_W  = 4;
    localparam int MICROOP_W = 5;

    // architectural register count
    localparam int NUM_VREGS = 32;

    typedef logic [ELEM_W-1:0]    elem_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [TICKET_W-1:0]  ticket_t;
    typedef logic [MICROOP_W-1:0] microop_t;

    // ticket 0 is reserved, numbering starts here
    localparam ticket_t FIRST_TICKET = 4'd1;

    // element-wise, vector-vector
    localparam microop_t OP_VADD_VV = 5'd0;
    localparam microop_t OP_VSUB_VV = 5'd1;
    localparam microop_t OP_VAND_VV = 5'd2;
    localparam microop_t OP_VOR_VV  = 5'd3;
    localparam microop_t OP_VXOR_VV = 5'd4;

    // vector-scalar
    localparam microop_t OP_VADD_VX = 5'd5;
    localparam microop_t OP_VMV_VX  = 5'd6;

    // sum of active src1 elements
    localparam microop_t OP_VREDSUM_VS = 5'd7;

endpackage
